/* hdl/ex_pkg.sv */
package ex_pkg;

    // Datapath width, one RV32 word
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ALU operation codes
    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10; // LUI

    // Branch types, JALR travels on its own flag
    localparam int BR_W = 3;

    localparam logic [BR_W-1:0] BR_NONE = 3'd0;
    localparam logic [BR_W-1:0] BR_EQ   = 3'd1;
    localparam logic [BR_W-1:0] BR_NE   = 3'd2;
    localparam logic [BR_W-1:0] BR_LT   = 3'd3;
    localparam logic [BR_W-1:0] BR_GE   = 3'd4;
    localparam logic [BR_W-1:0] BR_LTU  = 3'd5;
    localparam logic [BR_W-1:0] BR_GEU  = 3'd6;
    localparam logic [BR_W-1:0] BR_JAL  = 3'd7;

    // Forwarding selects
    // Code 3 is unused and behaves like FWD_MEM
    localparam int FWD_W = 2;

    localparam logic [FWD_W-1:0] FWD_NONE = 2'd0;
    localparam logic [FWD_W-1:0] FWD_MEM  = 2'd1;
    localparam logic [FWD_W-1:0] FWD_WB   = 2'd2;

endpackage

/* hdl/operand_forward.sv */
`timescale 1ns/1ns

module operand_forward (
    input  logic [ex_pkg::XLEN-1:0]  data_a_i,
    input  logic [ex_pkg::XLEN-1:0]  data_b_i,
    input  logic [ex_pkg::XLEN-1:0]  store_data_i,
    input  logic [ex_pkg::XLEN-1:0]  data_from_mem_i,
    input  logic [ex_pkg::XLEN-1:0]  data_from_wb_i,
    input  logic [ex_pkg::FWD_W-1:0] fwd_a_sel_i,
    input  logic [ex_pkg::FWD_W-1:0] fwd_b_sel_i,
    input  logic [ex_pkg::FWD_W-1:0] fwd_store_sel_i,
    output logic [ex_pkg::XLEN-1:0]  operand_a_o,
    output logic [ex_pkg::XLEN-1:0]  operand_b_o,
    output logic [ex_pkg::XLEN-1:0]  store_data_o
);

    // One decode rule for all three selects
    function automatic logic [ex_pkg::XLEN-1:0] pick_source(
        input logic [ex_pkg::FWD_W-1:0] sel,
        input logic [ex_pkg::XLEN-1:0]  decoded,
        input logic [ex_pkg::XLEN-1:0]  from_mem,
        input logic [ex_pkg::XLEN-1:0]  from_wb
    );
        logic [ex_pkg::XLEN-1:0] chosen;
        case (sel)
            ex_pkg::FWD_NONE: chosen = decoded;
            ex_pkg::FWD_WB:   chosen = from_wb;
            ex_pkg::FWD_MEM:  chosen = from_mem;
            default:          chosen = from_mem; // Spare code, memory stage wins
        endcase
        return chosen;
    endfunction

    always_comb begin
        operand_a_o  = pick_source(fwd_a_sel_i, data_a_i, data_from_mem_i, data_from_wb_i);
        operand_b_o  = pick_source(fwd_b_sel_i, data_b_i, data_from_mem_i, data_from_wb_i);
        store_data_o = pick_source(fwd_store_sel_i, store_data_i,
                                   data_from_mem_i, data_from_wb_i);
    end

endmodule

/* hdl/alu_shifter.sv */
`timescale 1ns/1ns

module alu_shifter (
    input  logic [ex_pkg::XLEN-1:0]     operand_a_i,
    input  logic [ex_pkg::XLEN-1:0]     operand_b_i,
    input  logic [ex_pkg::ALU_OP_W-1:0] alu_op_i,
    output logic [ex_pkg::XLEN-1:0]     result_o,
    output logic                        zero_o,
    output logic                        lt_o,
    output logic                        ltu_o
);

    logic [ex_pkg::XLEN-1:0] sum;
    logic [ex_pkg::XLEN:0]   diff_ext;   // Extra bit holds the borrow
    logic [ex_pkg::XLEN-1:0] diff;
    logic [4:0]              shamt;
    logic                    sign_a;
    logic                    sign_b;
    logic                    sign_d;
    logic                    overflow;

    assign sum      = operand_a_i + operand_b_i;
    assign diff_ext = {1'b0, operand_a_i} - {1'b0, operand_b_i};
    assign diff     = diff_ext[ex_pkg::XLEN-1:0];
    assign shamt    = operand_b_i[4:0];

    assign sign_a = operand_a_i[ex_pkg::XLEN-1];
    assign sign_b = operand_b_i[ex_pkg::XLEN-1];
    assign sign_d = diff[ex_pkg::XLEN-1];

    // Signed overflow of a - b: operand signs differ and result sign flips from a
    assign overflow = (sign_a ^ sign_b) & (sign_a ^ sign_d);

    // Flags always come from the subtractor, shared with branch compare
    assign zero_o = (diff == '0);
    assign lt_o   = sign_d ^ overflow;
    assign ltu_o  = diff_ext[ex_pkg::XLEN];

    always_comb begin
        case (alu_op_i)
            ex_pkg::ALU_ADD:    result_o = sum;
            ex_pkg::ALU_SUB:    result_o = diff;
            ex_pkg::ALU_AND:    result_o = operand_a_i & operand_b_i;
            ex_pkg::ALU_OR:     result_o = operand_a_i | operand_b_i;
            ex_pkg::ALU_XOR:    result_o = operand_a_i ^ operand_b_i;
            ex_pkg::ALU_SLL:    result_o = operand_a_i << shamt;
            ex_pkg::ALU_SRL:    result_o = operand_a_i >> shamt;
            ex_pkg::ALU_SRA:    result_o = $unsigned($signed(operand_a_i) >>> shamt);
            ex_pkg::ALU_SLT: begin
                result_o = '0;
                result_o[0] = lt_o;
            end
            ex_pkg::ALU_SLTU: begin
                result_o = '0;
                result_o[0] = ltu_o;
            end
            ex_pkg::ALU_PASS_B: result_o = operand_b_i; // LUI immediate
            default:            result_o = sum;
        endcase
    end

endmodule

/* hdl/branch_resolver.sv */
`timescale 1ns/1ns

module branch_resolver (
    input  logic                    valid_i,
    input  logic [ex_pkg::BR_W-1:0] branch_sel_i,
    input  logic                    is_jalr_i,
    input  logic                    zero_i,
    input  logic                    lt_i,
    input  logic                    ltu_i,
    input  logic [ex_pkg::XLEN-1:0] alu_result_i,
    input  logic [ex_pkg::XLEN-1:0] pc_plus_i,
    input  logic [ex_pkg::XLEN-1:0] branch_target_i,
    input  logic                    branch_prediction_i,
    output logic                    misprediction_o,
    output logic [ex_pkg::XLEN-1:0] correct_pc_o
);

    logic cond_taken;
    logic taken;

    always_comb begin
        case (branch_sel_i)
            ex_pkg::BR_EQ:  cond_taken = zero_i;
            ex_pkg::BR_NE:  cond_taken = !zero_i;
            ex_pkg::BR_LT:  cond_taken = lt_i;
            ex_pkg::BR_GE:  cond_taken = !lt_i;
            ex_pkg::BR_LTU: cond_taken = ltu_i;
            ex_pkg::BR_GEU: cond_taken = !ltu_i;
            ex_pkg::BR_JAL: cond_taken = 1'b1;
            default:        cond_taken = 1'b0;  // BR_NONE
        endcase
    end

    assign taken = cond_taken | is_jalr_i; // Jumps always redirect

    // Prediction check only counts for a live instruction
    assign misprediction_o = valid_i & (taken ^ branch_prediction_i);

    always_comb begin
        if (is_jalr_i) begin
            correct_pc_o = {alu_result_i[ex_pkg::XLEN-1:1], 1'b0}; // rs1 + imm, bit 0 cleared
        end else if (taken) begin
            correct_pc_o = branch_target_i;
        end else begin
            correct_pc_o = pc_plus_i;
        end
    end

endmodule

/* hdl/ex_mem_register.sv */
`timescale 1ns/1ns

module ex_mem_register (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          valid_i,
    input  logic                          stall_i,
    input  logic                          link_i,
    input  logic [ex_pkg::XLEN-1:0]       alu_result_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_plus_i,
    input  logic [ex_pkg::XLEN-1:0]       store_data_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_i,
    input  logic                          is_load_i,
    input  logic                          is_store_i,
    input  logic                          reg_write_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] rd_addr_i,
    output logic                          valid_o,
    output logic [ex_pkg::XLEN-1:0]       result_o,
    output logic [ex_pkg::XLEN-1:0]       store_data_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output logic                          reg_write_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic                          trace_valid_o,
    output logic [ex_pkg::XLEN-1:0]       trace_pc_o,
    output logic [ex_pkg::XLEN-1:0]       trace_mem_addr_o,
    output logic [ex_pkg::XLEN-1:0]       trace_reg_data_o,
    output logic [ex_pkg::XLEN-1:0]       trace_store_data_o
);

    logic [ex_pkg::XLEN-1:0] stage_result;
    logic                    is_mem_op;

    assign stage_result = link_i ? pc_plus_i : alu_result_i; // JAL/JALR write the return address
    assign is_mem_op    = is_load_i | is_store_i;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_o            <= 1'b0;
            result_o           <= '0;
            store_data_o       <= '0;
            mem_read_o         <= 1'b0;
            mem_write_o        <= 1'b0;
            reg_write_o        <= 1'b0;
            rd_addr_o          <= '0;
            trace_valid_o      <= 1'b0;
            trace_pc_o         <= '0;
            trace_mem_addr_o   <= '0;
            trace_reg_data_o   <= '0;
            trace_store_data_o <= '0;
        end else if (!stall_i) begin           // Memory stage back-pressure freezes everything
            valid_o            <= valid_i;
            result_o           <= stage_result;
            store_data_o       <= store_data_i;
            mem_read_o         <= valid_i & is_load_i;
            mem_write_o        <= valid_i & is_store_i;
            reg_write_o        <= valid_i & reg_write_i;
            rd_addr_o          <= rd_addr_i;
            trace_valid_o      <= valid_i;
            trace_pc_o         <= pc_i;
            trace_mem_addr_o   <= is_mem_op ? stage_result : '0;
            trace_reg_data_o   <= is_mem_op ? '0 : stage_result;
            trace_store_data_o <= is_store_i ? store_data_i : '0;
        end
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          valid_i,
    input  logic                          stall_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_plus_i,
    input  logic [ex_pkg::XLEN-1:0]       branch_target_i,
    input  logic [ex_pkg::XLEN-1:0]       data_a_i,
    input  logic [ex_pkg::XLEN-1:0]       data_b_i,
    input  logic [ex_pkg::XLEN-1:0]       store_data_i,
    input  logic [ex_pkg::XLEN-1:0]       data_from_mem_i,
    input  logic [ex_pkg::XLEN-1:0]       data_from_wb_i,
    input  logic [ex_pkg::FWD_W-1:0]      fwd_a_sel_i,
    input  logic [ex_pkg::FWD_W-1:0]      fwd_b_sel_i,
    input  logic [ex_pkg::FWD_W-1:0]      fwd_store_sel_i,
    input  logic [ex_pkg::ALU_OP_W-1:0]   alu_op_i,
    input  logic [ex_pkg::BR_W-1:0]       branch_sel_i,
    input  logic                          is_jalr_i,
    input  logic                          link_i,
    input  logic                          is_load_i,
    input  logic                          is_store_i,
    input  logic                          reg_write_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic                          branch_prediction_i,
    output logic                          misprediction_o,
    output logic [ex_pkg::XLEN-1:0]       correct_pc_o,
    output logic                          valid_o,
    output logic [ex_pkg::XLEN-1:0]       result_o,
    output logic [ex_pkg::XLEN-1:0]       store_data_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output logic                          reg_write_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic                          trace_valid_o,
    output logic [ex_pkg::XLEN-1:0]       trace_pc_o,
    output logic [ex_pkg::XLEN-1:0]       trace_mem_addr_o,
    output logic [ex_pkg::XLEN-1:0]       trace_reg_data_o,
    output logic [ex_pkg::XLEN-1:0]       trace_store_data_o
);

    logic [ex_pkg::XLEN-1:0] operand_a;
    logic [ex_pkg::XLEN-1:0] operand_b;
    logic [ex_pkg::XLEN-1:0] store_data;  // Store value after forwarding
    logic [ex_pkg::XLEN-1:0] alu_result;
    logic                    zero;
    logic                    lt;
    logic                    ltu;

    operand_forward u_forward (
        .data_a_i        (data_a_i),
        .data_b_i        (data_b_i),
        .store_data_i    (store_data_i),
        .data_from_mem_i (data_from_mem_i),
        .data_from_wb_i  (data_from_wb_i),
        .fwd_a_sel_i     (fwd_a_sel_i),
        .fwd_b_sel_i     (fwd_b_sel_i),
        .fwd_store_sel_i (fwd_store_sel_i),
        .operand_a_o     (operand_a),
        .operand_b_o     (operand_b),
        .store_data_o    (store_data)
    );

    alu_shifter u_alu (
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .alu_op_i    (alu_op_i),
        .result_o    (alu_result),
        .zero_o      (zero),
        .lt_o        (lt),
        .ltu_o       (ltu)
    );

    branch_resolver u_branch (
        .valid_i             (valid_i),
        .branch_sel_i        (branch_sel_i),
        .is_jalr_i           (is_jalr_i),
        .zero_i              (zero),
        .lt_i                (lt),
        .ltu_i               (ltu),
        .alu_result_i        (alu_result),
        .pc_plus_i           (pc_plus_i),
        .branch_target_i     (branch_target_i),
        .branch_prediction_i (branch_prediction_i),
        .misprediction_o     (misprediction_o),
        .correct_pc_o        (correct_pc_o)
    );

    ex_mem_register u_ex_mem (
        .clk                (clk),
        .reset              (reset),
        .valid_i            (valid_i),
        .stall_i            (stall_i),
        .link_i             (link_i),
        .alu_result_i       (alu_result),
        .pc_plus_i          (pc_plus_i),
        .store_data_i       (store_data),
        .pc_i               (pc_i),
        .is_load_i          (is_load_i),
        .is_store_i         (is_store_i),
        .reg_write_i        (reg_write_i),
        .rd_addr_i          (rd_addr_i),
        .valid_o            (valid_o),
        .result_o           (result_o),
        .store_data_o       (store_data_o),
        .mem_read_o         (mem_read_o),
        .mem_write_o        (mem_write_o),
        .reg_write_o        (reg_write_o),
        .rd_addr_o          (rd_addr_o),
        .trace_valid_o      (trace_valid_o),
        .trace_pc_o         (trace_pc_o),
        .trace_mem_addr_o   (trace_mem_addr_o),
        .trace_reg_data_o   (trace_reg_data_o),
        .trace_store_data_o (trace_store_data_o)
    );

endmodule

/* tests/execute_stage_checker.sv */
`timescale 1ns/1ns

module execute_stage_checker (
    input logic                          clk,
    input logic                          reset,
    input logic                          valid_i,
    input logic                          stall_i,
    input logic                          misprediction_o,
    input logic                          valid_o,
    input logic                          mem_read_o,
    input logic                          mem_write_o,
    input logic                          reg_write_o,
    input logic                          trace_valid_o,
    input logic [ex_pkg::REG_ADDR_W-1:0] rd_addr_o,
    input logic [ex_pkg::XLEN-1:0]       result_o,
    input logic [ex_pkg::XLEN-1:0]       store_data_o,
    input logic [ex_pkg::XLEN-1:0]       trace_pc_o,
    input logic [ex_pkg::XLEN-1:0]       trace_mem_addr_o,
    input logic [ex_pkg::XLEN-1:0]       trace_reg_data_o,
    input logic [ex_pkg::XLEN-1:0]       trace_store_data_o
);

    logic ctrl_low;

    assign ctrl_low = !valid_o && !mem_read_o && !mem_write_o && !reg_write_o && !trace_valid_o;

    in_reset: assert property (@(posedge clk) !reset |-> ctrl_low)
        else $error("control outputs active during reset");

    // Back-pressure freezes the whole EX/MEM register
    hold_on_stall: assert property (@(posedge clk) disable iff (!reset)
        stall_i |=> $stable({valid_o, mem_read_o, mem_write_o, reg_write_o, trace_valid_o,
                             rd_addr_o, result_o, store_data_o, trace_pc_o,
                             trace_mem_addr_o, trace_reg_data_o, trace_store_data_o}))
        else $error("EX/MEM register changed while stalled");

    valid_follows: assert property (@(posedge clk) disable iff (!reset)
        !stall_i |=> valid_o == $past(valid_i))
        else $error("valid_o did not follow valid_i");

    bubble_quiet: assert property (@(posedge clk) disable iff (!reset)
        !valid_i && !stall_i |=> ctrl_low)
        else $error("control outputs active after a bubble");

    mispredict_gated: assert property (@(posedge clk) disable iff (!reset)
        !valid_i |-> !misprediction_o)
        else $error("misprediction raised without a valid instruction");

endmodule

bind execute_stage execute_stage_checker u_checker (.*);

/* tests/execute_stage_tb.sv */
`timescale 1ns/1ns

module execute_stage_tb;

    localparam int PHASES   = 6;
    localparam int CYCLES   = 40;                              // Instructions per phase
    localparam int LIMIT_NS = (PHASES * CYCLES + 2 + 20) * 20; // Reset and a margin on top

    logic clk = 1'b0;
    logic reset = 1'b0;
    logic valid_i = 1'b0, stall_i = 1'b0, is_jalr_i = 1'b0, link_i = 1'b0;
    logic is_load_i = 1'b0, is_store_i = 1'b0, reg_write_i = 1'b0, branch_prediction_i = 1'b0;
    logic [ex_pkg::XLEN-1:0] pc_i = '0, pc_plus_i = '0, branch_target_i = '0;
    logic [ex_pkg::XLEN-1:0] data_a_i = '0, data_b_i = '0, store_data_i = '0;
    logic [ex_pkg::XLEN-1:0] data_from_mem_i = '0, data_from_wb_i = '0;
    logic [ex_pkg::FWD_W-1:0] fwd_a_sel_i = '0, fwd_b_sel_i = '0, fwd_store_sel_i = '0;
    logic [ex_pkg::ALU_OP_W-1:0] alu_op_i = '0;
    logic [ex_pkg::BR_W-1:0] branch_sel_i = '0;
    logic [ex_pkg::REG_ADDR_W-1:0] rd_addr_i = '0, rd_addr_o;
    logic misprediction_o, valid_o, mem_read_o, mem_write_o, reg_write_o, trace_valid_o;
    logic [ex_pkg::XLEN-1:0] correct_pc_o, result_o, store_data_o, trace_pc_o;
    logic [ex_pkg::XLEN-1:0] trace_mem_addr_o, trace_reg_data_o, trace_store_data_o;

    // Expected EX/MEM register fields
    logic [ex_pkg::XLEN-1:0] pend [7] = '{default: '0};
    logic [ex_pkg::XLEN-1:0] expd [7] = '{default: '0};
    logic [31:0] seed = 32'd71957;
    logic        stall_prev = 1'b0;
    logic        run_ended = 1'b0;
    string       names [PHASES] = '{"alu", "forward", "branch", "stall", "valid", "trace"};

    execute_stage u_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] hi;
        seed = seed * 32'd1103515245 + 32'd12345;
        hi   = seed;
        seed = seed * 32'd1103515245 + 32'd12345;
        return {hi[31:16], seed[31:16]};                      // Upper halves since low bits are weak
    endfunction

    function automatic logic [31:0] forward_model(input logic [1:0] sel,
                                                  input logic [31:0] dec, mem, wb);
        if (sel == 2'd0) return dec;
        if (sel == 2'd2) return wb;
        return mem;                                           // Memory stage for the spare code too
    endfunction

    function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a, b);
        logic [31:0] sh;
        sh = a >> b[4:0];
        case (op)
            ex_pkg::ALU_SUB:    return a - b;
            ex_pkg::ALU_AND:    return a & b;
            ex_pkg::ALU_OR:     return a | b;
            ex_pkg::ALU_XOR:    return a ^ b;
            ex_pkg::ALU_SLL:    return a << b[4:0];
            ex_pkg::ALU_SRL:    return sh;
            ex_pkg::ALU_SRA:    return a[31] ? (sh | ~(32'hffff_ffff >> b[4:0])) : sh;
            ex_pkg::ALU_SLT:    return {31'd0, $signed(a) < $signed(b)};
            ex_pkg::ALU_SLTU:   return {31'd0, a < b};
            ex_pkg::ALU_PASS_B: return b;
            default:            return a + b;
        endcase
    endfunction

    function automatic logic taken_model(input logic [2:0] br, input logic jalr,
                                         input logic [31:0] a, b);
        logic c;
        case (br)
            ex_pkg::BR_EQ:  c = (a == b);
            ex_pkg::BR_NE:  c = (a != b);
            ex_pkg::BR_LT:  c = ($signed(a) < $signed(b));
            ex_pkg::BR_GE:  c = ($signed(a) >= $signed(b));
            ex_pkg::BR_LTU: c = (a < b);
            ex_pkg::BR_GEU: c = (a >= b);
            ex_pkg::BR_JAL: c = 1'b1;
            default:        c = 1'b0;
        endcase
        return c | jalr;
    endfunction

    task automatic check_value(input string test, input string sig,
                               input logic [31:0] expv, input logic [31:0] actv);
        assert (actv === expv) else begin
            run_ended = 1'b1;
            $display("mismatch %s %s expected %h actual %h", test, sig, expv, actv);
            $display(">>> FAIL");
            $fatal(1, "%s check failed", sig);
        end
    endtask

    task automatic run_instruction(input int phase, input int i);
        logic [31:0] r, k, da, db, ds, dm, dw, pc, pcp, tgt;
        logic [31:0] a, b, sd, alu, stage, cpc;
        logic [3:0]  op;
        logic [2:0]  br;
        logic [1:0]  fa, fb, fs;
        logic        v, st, jalr, lnk, ld, sto, pred, tk;
        @(posedge clk);
        if (!stall_prev) begin
            expd = pend;                                      // DUT took the last inputs here
        end
        r    = next_rand();
        k    = (phase == 0) ? 32'(i % 11) : next_rand() % 32'd11;
        op   = (phase == 2) ? ex_pkg::ALU_ADD : k[3:0];      // JALR target needs the sum
        v    = (phase == 4) ? r[0] : 1'b1;
        st   = (phase == 3) ? r[1] : 1'b0;
        fa   = (phase == 1) ? r[3:2] : ex_pkg::FWD_NONE;
        fb   = (phase == 1) ? r[5:4] : ex_pkg::FWD_NONE;
        fs   = (phase == 1) ? r[7:6] : ex_pkg::FWD_NONE;
        br   = (phase == 2) ? r[10:8] : ex_pkg::BR_NONE;
        jalr = (phase == 2) && r[11] && (br == ex_pkg::BR_NONE);
        lnk  = jalr || (br == ex_pkg::BR_JAL);
        sto  = (phase == 1 || phase == 5) && r[13];
        ld   = (phase == 5) && !r[13] && r[14];
        pred = r[12];
        da   = next_rand();
        db   = (phase == 2 && r[15]) ? da : next_rand();     // Equal operands now and then
        ds   = next_rand();
        dm   = next_rand();
        dw   = next_rand();
        pc   = next_rand() & 32'hffff_fffc;
        pcp  = pc + 32'd4;
        tgt  = next_rand() & 32'hffff_fffc;
        a     = forward_model(fa, da, dm, dw);
        b     = forward_model(fb, db, dm, dw);
        sd    = forward_model(fs, ds, dm, dw);
        alu   = alu_model(op, a, b);
        tk    = taken_model(br, jalr, a, b);
        stage = lnk ? pcp : alu;
        cpc   = jalr ? (alu & 32'hffff_fffe) : (tk ? tgt : pcp);
        valid_i             <= v;
        stall_i             <= st;
        pc_i                <= pc;
        pc_plus_i           <= pcp;
        branch_target_i     <= tgt;
        data_a_i            <= da;
        data_b_i            <= db;
        store_data_i        <= ds;
        data_from_mem_i     <= dm;
        data_from_wb_i      <= dw;
        fwd_a_sel_i         <= fa;
        fwd_b_sel_i         <= fb;
        fwd_store_sel_i     <= fs;
        alu_op_i            <= op;
        branch_sel_i        <= br;
        is_jalr_i           <= jalr;
        link_i              <= lnk;
        is_load_i           <= ld;
        is_store_i          <= sto;
        reg_write_i         <= !sto;
        rd_addr_i           <= r[20:16];
        branch_prediction_i <= pred;
        pend[0] = stage;
        pend[1] = (ld || sto) ? stage : '0;
        pend[2] = (ld || sto) ? '0 : stage;
        pend[3] = sto ? sd : '0;
        pend[4] = {23'd0, r[20:16], v & !sto, v, v & ld, v & sto};
        pend[5] = sd;
        pend[6] = pc;
        stall_prev = st;
        @(negedge clk);
        check_value(names[phase], "misprediction_o", 32'(v & (tk ^ pred)), 32'(misprediction_o));
        check_value(names[phase], "correct_pc_o", cpc, correct_pc_o);
        check_value(names[phase], "valid_o", 32'(expd[4][2]), 32'(valid_o));
        check_value(names[phase], "trace_valid_o", 32'(expd[4][2]), 32'(trace_valid_o));
        if (expd[4][2]) begin
            check_value(names[phase], "result_o", expd[0], result_o);
            check_value(names[phase], "trace_mem_addr_o", expd[1], trace_mem_addr_o);
            check_value(names[phase], "trace_reg_data_o", expd[2], trace_reg_data_o);
            check_value(names[phase], "trace_store_data_o", expd[3], trace_store_data_o);
            check_value(names[phase], "store_data_o", expd[5], store_data_o);
            check_value(names[phase], "trace_pc_o", expd[6], trace_pc_o);
            check_value(names[phase], "mem_read_o", 32'(expd[4][1]), 32'(mem_read_o));
            check_value(names[phase], "mem_write_o", 32'(expd[4][0]), 32'(mem_write_o));
            check_value(names[phase], "reg_write_o", 32'(expd[4][3]), 32'(reg_write_o));
            check_value(names[phase], "rd_addr_o", 32'(expd[4][8:4]), 32'(rd_addr_o));
        end
    endtask

    initial begin
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        for (int p = 0; p < PHASES; p++) begin
            for (int i = 0; i < CYCLES; i++) begin
                run_instruction(p, i);
            end
        end
        run_ended = 1'b1;
        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        run_ended = 1'b1;
        $display("watchdog expired after %0d ns without finishing the tests", LIMIT_NS);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

    // A stop from a failed checker assertion ends here without a verdict
    final begin
        if (!run_ended) $display(">>> FAIL");
    end

endmodule

/* filelist.f */
hdl/ex_pkg.sv
hdl/operand_forward.sv
hdl/alu_shifter.sv
hdl/branch_resolver.sv
hdl/ex_mem_register.sv
hdl/execute_stage.sv
tests/execute_stage_checker.sv
tests/execute_stage_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module execute_stage_tb \
		-f filelist.f --Mdir obj_dir -o execute_stage_sim
	./obj_dir/execute_stage_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
